// ==== source/uc_pkg.sv ====
/*
 * Shared definitions for the microcode control core.
 * Condition codes, flag bit positions and microword field widths.
 * Modules pull these in with a wildcard import in their header.
 */

package uc_pkg;

   ////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////

   localparam int COND_W  = 4;   // Condition field in the microword
   localparam int OPC_W   = 4;   // Opcode bits used for dispatch
   localparam int IR_W    = 16;  // Instruction register
   localparam int FLAGS_W = 4;   // V, L, Z, N

   // Flag positions inside the flags vector
   localparam int FLAG_V = 0;
   localparam int FLAG_L = 1;
   localparam int FLAG_Z = 2;
   localparam int FLAG_N = 3;

   // Skip condition codes, skip happens when the selected source reads 0
   typedef enum logic [COND_W-1:0] {
      COND_ALWAYS = 4'd0,   // Never skips
      COND_IR0    = 4'd1,
      COND_IR1    = 4'd2,
      COND_IR2    = 4'd3,
      COND_IR3    = 4'd4,
      COND_IR4    = 4'd5,
      COND_IR5    = 4'd6,
      COND_IR6    = 4'd7,
      COND_EXT1   = 4'd8,   // Reserved expansion inputs
      COND_EXT2   = 4'd9,
      COND_EXT3   = 4'd10,
      COND_FV     = 4'd11,
      COND_FL     = 4'd12,
      COND_FZ     = 4'd13,
      COND_FN     = 4'd14,
      COND_BRANCH = 4'd15   // Branch test result
   } cond_t;

   // Microword is end_inst, flag_we, cond, ctrl from the top bit down
   function automatic int uword_width(int ctrl_w);
      return ctrl_w + COND_W + 2;
   endfunction

endpackage

// ==== source/ucode_store.sv ====
/*
 * Writable microcode memory.
 * Loaded through a clocked write port, read combinationally so the
 * sequencer sees the microword in the same cycle as its address.
 */

`timescale 1ns/1ps

module ucode_store
   import uc_pkg::*;
#(
   parameter int UPC_W   = 6,
   parameter int UWORD_W = uword_width(12)   // 12 control lines by default
) (
   input  logic               clk4,
   input  logic               we,      // Load strobe
   input  logic [UPC_W-1:0]   waddr,
   input  logic [UWORD_W-1:0] wdata,
   input  logic [UPC_W-1:0]   raddr,   // Micro-program counter
   output logic [UWORD_W-1:0] rdata    // Current microword
);

   localparam int DEPTH = 2 ** UPC_W;

   // One word per micro-address, contents undefined until loaded
   logic [UWORD_W-1:0] mem [DEPTH];

   ////////////////////////////////////////////////////////////
   // Load port
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk4) begin
      if (we) begin
         mem[waddr] <= wdata;   // New word visible from next cycle
      end
   end

   ////////////////////////////////////////////////////////////
   // Fetch port
   ////////////////////////////////////////////////////////////

   // Asynchronous read
   // Fetch and decode both happen inside one micro-cycle
   assign rdata = mem[raddr];

endmodule

// ==== source/flag_reg.sv ====
/*
 * Processor flag register for V, L, Z and N.
 * All four load together from the ALU result lines when the
 * current microword asserts its flag write strobe.
 */

`timescale 1ns/1ps

module flag_reg
   import uc_pkg::*;
(
   input  logic               clk4,
   input  logic               arst_n,
   input  logic               we,      // flag_we from the sequencer
   input  logic               alu_v,   // Overflow
   input  logic               alu_l,   // Link / carry
   input  logic               alu_z,   // Zero
   input  logic               alu_n,   // Negative
   output logic [FLAGS_W-1:0] flags
);

   logic [FLAGS_W-1:0] flags_d;

   // Pack ALU outputs in flag-vector order
   always_comb begin
      flags_d         = '0;
      flags_d[FLAG_V] = alu_v;
      flags_d[FLAG_L] = alu_l;
      flags_d[FLAG_Z] = alu_z;
      flags_d[FLAG_N] = alu_n;
   end

   ////////////////////////////////////////////////////////////
   // Flag storage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         flags <= '0;        // All flags clear out of reset
      end else if (we) begin
         flags <= flags_d;   // Whole set at once, no partial update
      end
   end

   // A skipped or stalled word never reaches here with we high
   // The sequencer already masks the strobe

endmodule

// ==== source/skip_unit.sv ====
/*
 * Skip unit of the control core.
 * Picks one condition source per micro-instruction and registers an
 * active-low skip that covers the following micro-instruction.
 */

`timescale 1ns/1ps

module skip_unit
   import uc_pkg::*;
(
   input  logic               clk4,
   input  logic               arst_n,
   input  logic [IR_W-1:0]    ir,
   input  cond_t              cond,       // From the current microword
   input  logic [FLAGS_W-1:0] flags,
   input  logic [2:0]         cext,       // Reserved expansion conditions
   input  logic               nskipext,   // External skip request, active low
   output logic               nskip       // Registered, active low
);

   ////////////////////////////////////////////////////////////
   // Branch test
   ////////////////////////////////////////////////////////////

   logic hit_v;
   logic hit_l;
   logic hit_z;
   logic hit_n;
   logic br_any;
   logic br_test;

   // IR[3:0] masks the flags, bit 0 for V up to bit 3 for N
   assign hit_v = flags[FLAG_V] & ir[0];
   assign hit_l = flags[FLAG_L] & ir[1];
   assign hit_z = flags[FLAG_Z] & ir[2];
   assign hit_n = flags[FLAG_N] & ir[3];

   assign br_any  = hit_v | hit_l | hit_z | hit_n;
   assign br_test = br_any ^ ir[4];   // IR4 inverts the sense

   ////////////////////////////////////////////////////////////
   // Condition select
   ////////////////////////////////////////////////////////////

   logic sel;       // 0 means skip the next word
   logic nskip_d;

   always_comb begin
      unique case (cond)
         COND_ALWAYS: sel = 1'b1;   // Nothing to test
         COND_IR0:    sel = ir[0];
         COND_IR1:    sel = ir[1];
         COND_IR2:    sel = ir[2];
         COND_IR3:    sel = ir[3];
         COND_IR4:    sel = ir[4];
         COND_IR5:    sel = ir[5];
         COND_IR6:    sel = ir[6];
         COND_EXT1:   sel = cext[0];
         COND_EXT2:   sel = cext[1];
         COND_EXT3:   sel = cext[2];
         COND_FV:     sel = flags[FLAG_V];
         COND_FL:     sel = flags[FLAG_L];
         COND_FZ:     sel = flags[FLAG_Z];
         COND_FN:     sel = flags[FLAG_N];
         COND_BRANCH: sel = br_test;
         default:     sel = 1'b1;
      endcase
   end

   // External request overrides whatever the condition said
   assign nskip_d = sel & nskipext;

   ////////////////////////////////////////////////////////////
   // Skip register
   ////////////////////////////////////////////////////////////

   // Holds for exactly one micro-instruction
   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         nskip <= 1'b1;   // Nothing skipped after reset
      end else begin
         nskip <= nskip_d;
      end
   end

endmodule

// ==== source/micro_seq.sv ====
/*
 * Microsequencer with opcode dispatch.
 * Steps the micro-program counter and splits the microword into its
 * fields, masking them while a word is skipped or run is low.
 */

`timescale 1ns/1ps

module micro_seq
   import uc_pkg::*;
#(
   parameter int UPC_W  = 6,
   parameter int CTRL_W = 12
) (
   input  logic                          clk4,
   input  logic                          arst_n,
   input  logic                          run,      // Stall when low
   input  logic [OPC_W-1:0]              ir_opc,   // IR[15:12]
   input  logic [uword_width(CTRL_W)-1:0] uword,
   input  logic                          nskip,    // Current word skipped when low
   output logic [UPC_W-1:0]              upc,
   output cond_t                         cond,
   output logic                          flag_we,
   output logic [CTRL_W-1:0]             ctrl
);

   localparam int UWORD_W  = uword_width(CTRL_W);
   localparam int END_BIT  = UWORD_W - 1;
   localparam int FWE_BIT  = UWORD_W - 2;
   localparam int COND_LSB = CTRL_W;

   // Dispatch address needs room for the opcode
   if (UPC_W < OPC_W) begin : g_width_check
      $error("UPC_W must be at least OPC_W");
   end

   ////////////////////////////////////////////////////////////
   // Field decode
   ////////////////////////////////////////////////////////////

   logic              w_end;
   logic              w_fwe;
   cond_t             w_cond;
   logic [CTRL_W-1:0] w_ctrl;
   logic              active;   // Word takes effect this cycle

   assign w_end  = uword[END_BIT];
   assign w_fwe  = uword[FWE_BIT];
   assign w_cond = cond_t'(uword[COND_LSB +: COND_W]);
   assign w_ctrl = uword[CTRL_W-1:0];

   assign active = run & nskip;

   // Skipped or stalled words turn into a no-op
   assign cond    = active ? w_cond : COND_ALWAYS;   // Lets nskip recover
   assign flag_we = active & w_fwe;
   assign ctrl    = active ? w_ctrl : '0;

   ////////////////////////////////////////////////////////////
   // Micro-program counter
   ////////////////////////////////////////////////////////////

   logic [UPC_W-1:0] upc_disp;
   logic [UPC_W-1:0] upc_d;

   // Opcode in the top bits, one block of words per instruction
   assign upc_disp = UPC_W'(ir_opc) << (UPC_W - OPC_W);

   always_comb begin
      if (!run) begin
         upc_d = upc;                 // Hold while stalled
      end else if (nskip && w_end) begin
         upc_d = upc_disp;            // End of instruction
      end else begin
         upc_d = upc + 1'b1;          // Skipped end_inst falls through here
      end
   end

   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         upc <= '0;
      end else begin
         upc <= upc_d;
      end
   end

endmodule

// ==== source/control_top.sv ====
/*
 * Top level of the microcode control core.
 * Connects microcode store, sequencer, flag register and skip unit.
 */

`timescale 1ns/1ps

module control_top
   import uc_pkg::*;
#(
   parameter int UPC_W  = 6,
   parameter int CTRL_W = 12
) (
   input  logic                           clk4,
   input  logic                           arst_n,
   input  logic                           run,
   input  logic [IR_W-1:0]                ir,
   input  logic                           alu_v,
   input  logic                           alu_l,
   input  logic                           alu_z,
   input  logic                           alu_n,
   input  logic [2:0]                     cext,
   input  logic                           nskipext,
   input  logic                           ucode_we,     // Microcode load
   input  logic [UPC_W-1:0]               ucode_addr,
   input  logic [uword_width(CTRL_W)-1:0] ucode_data,
   output logic [UPC_W-1:0]               upc,
   output logic [CTRL_W-1:0]              ctrl,
   output logic                           nskip,
   output logic [FLAGS_W-1:0]             flags
);

   localparam int UWORD_W = uword_width(CTRL_W);

   logic [UWORD_W-1:0] uword;     // Word at upc
   cond_t              cond;      // Gated condition
   logic               flag_we;   // Gated flag strobe

   ////////////////////////////////////////////////////////////
   // Store and sequencer
   ////////////////////////////////////////////////////////////

   ucode_store #(
      .UPC_W   (UPC_W),
      .UWORD_W (UWORD_W)
   ) u_store (
      .clk4  (clk4),
      .we    (ucode_we),
      .waddr (ucode_addr),
      .wdata (ucode_data),
      .raddr (upc),
      .rdata (uword)
   );

   micro_seq #(
      .UPC_W  (UPC_W),
      .CTRL_W (CTRL_W)
   ) u_seq (
      .clk4    (clk4),
      .arst_n  (arst_n),
      .run     (run),
      .ir_opc  (ir[IR_W-1 -: OPC_W]),   // Opcode field
      .uword   (uword),
      .nskip   (nskip),
      .upc     (upc),
      .cond    (cond),
      .flag_we (flag_we),
      .ctrl    (ctrl)
   );

   ////////////////////////////////////////////////////////////
   // Flags and skip logic
   ////////////////////////////////////////////////////////////

   flag_reg u_flags (
      .clk4   (clk4),
      .arst_n (arst_n),
      .we     (flag_we),
      .alu_v  (alu_v),
      .alu_l  (alu_l),
      .alu_z  (alu_z),
      .alu_n  (alu_n),
      .flags  (flags)
   );

   skip_unit u_skip (
      .clk4     (clk4),
      .arst_n   (arst_n),
      .ir       (ir),
      .cond     (cond),
      .flags    (flags),
      .cext     (cext),
      .nskipext (nskipext),
      .nskip    (nskip)    // Back to the sequencer
   );

endmodule

// ==== tests/control_asserts.sv ====
/*
 * Concurrent checks on the microsequencer, bound into every micro_seq.
 * Skip gating, opcode dispatch and single-word skip coverage.
 */

`timescale 1ns/1ps

module control_asserts
   import uc_pkg::*;
#(
   parameter int UPC_W  = 6,
   parameter int CTRL_W = 12
) (
   input logic                           clk4,
   input logic                           arst_n,
   input logic                           run,
   input logic [OPC_W-1:0]               ir_opc,
   input logic [uword_width(CTRL_W)-1:0] uword,
   input logic                           nskip,
   input logic [UPC_W-1:0]               upc,
   input logic [CTRL_W-1:0]              ctrl
);

   localparam int END_BIT = uword_width(CTRL_W) - 1;

   int n_fail = 0;   // Read by the testbench at the end

   ////////////////////////////////////////////////////////////
   // Properties
   ////////////////////////////////////////////////////////////

   // Skipped word drives no control lines
   a_skip_ctrl: assert property (@(posedge clk4) disable iff (!arst_n)
      !nskip |-> ctrl == '0)
      else begin
         n_fail++;
         $error("ctrl is active on a skipped word");
      end

   // Opcode lands in the top bits of upc, lower bits cleared
   a_dispatch: assert property (@(posedge clk4) disable iff (!arst_n)
      (run && nskip && uword[END_BIT])
      |=> (upc >> (UPC_W - OPC_W)) == UPC_W'($past(ir_opc)) && (upc << OPC_W) == '0)
      else begin
         n_fail++;
         $error("end_inst did not dispatch to the opcode address");
      end

   // One skip covers one word only
   a_skip_once: assert property (@(posedge clk4) disable iff (!arst_n)
      !nskip |=> nskip)
      else begin
         n_fail++;
         $error("nskip stayed low after a skipped word");
      end

endmodule

bind micro_seq control_asserts #(.UPC_W(UPC_W), .CTRL_W(CTRL_W)) u_asserts (.*);

// ==== tests/control_tb.sv ====
/*
 * Testbench for the microcode control core.
 * Loads microcode and per-cycle vectors from the stimulus file,
 * drives the DUT one micro-cycle per record and checks its outputs.
 */

`timescale 1ns/1ps

module control_tb
   import uc_pkg::*;
();

   localparam int UPC_W   = 6;
   localparam int CTRL_W  = 12;
   localparam int UWORD_W = uword_width(CTRL_W);
   localparam int PERIOD  = 100;   // ns

   logic               clk4;
   logic               arst_n;
   logic               run;
   logic [IR_W-1:0]    ir;
   logic               alu_v;
   logic               alu_l;
   logic               alu_z;
   logic               alu_n;
   logic [2:0]         cext;
   logic               nskipext;
   logic               ucode_we;
   logic [UPC_W-1:0]   ucode_addr;
   logic [UWORD_W-1:0] ucode_data;
   logic [UPC_W-1:0]   upc;
   logic [CTRL_W-1:0]  ctrl;
   logic               nskip;
   logic [FLAGS_W-1:0] flags;

   longint limit_ns = 0;   // Set once the stimulus length is known

   control_top #(
      .UPC_W  (UPC_W),
      .CTRL_W (CTRL_W)
   ) dut (.*);

   initial begin
      clk4 = 1'b0;
      forever #(PERIOD / 2) clk4 = ~clk4;
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "Output mismatch");
      end
   endtask

   task automatic bad_record(input string rec);
      $display("Malformed stimulus record: %s", rec);
      $display("TEST FAILED");
      $fatal(1, "Stimulus file cannot be parsed");
   endtask

   // Four consecutive microwords, one write per cycle
   task automatic load_block(input string rec);
      logic [UPC_W-1:0]   addr;
      logic [UWORD_W-1:0] w [4];
      int                 n;
      n = $sscanf(rec, "L %h %h %h %h %h", addr, w[0], w[1], w[2], w[3]);
      if (n != 5) begin
         bad_record(rec);
      end
      for (int i = 0; i < 4; i++) begin
         @(posedge clk4);
         ucode_we   <= 1'b1;
         ucode_addr <= addr;
         ucode_data <= w[i];
         addr = addr + 1'b1;
      end
   endtask

   // One micro-cycle of inputs, then compare just ahead of the next edge
   task automatic run_cycle(input string rec);
      logic               r_run;
      logic [IR_W-1:0]    r_ir;
      logic [3:0]         r_alu;     // Flag-vector order
      logic               r_rnd;     // ALU inputs are don't-care
      logic [2:0]         r_cext;
      logic               r_nsx;
      logic [UPC_W-1:0]   e_upc;
      logic [CTRL_W-1:0]  e_ctrl;
      logic               e_nskip;
      logic [FLAGS_W-1:0] e_flags;
      int                 n;
      n = $sscanf(rec, "C %h %h %h %h %h %h %h %h %h %h", r_run, r_ir, r_alu, r_rnd,
                  r_cext, r_nsx, e_upc, e_ctrl, e_nskip, e_flags);
      if (n != 10) begin
         bad_record(rec);
      end
      if (r_rnd) begin
         r_alu = 4'($urandom);
      end
      @(posedge clk4);
      run      <= r_run;
      ir       <= r_ir;
      alu_v    <= r_alu[FLAG_V];
      alu_l    <= r_alu[FLAG_L];
      alu_z    <= r_alu[FLAG_Z];
      alu_n    <= r_alu[FLAG_N];
      cext     <= r_cext;
      nskipext <= r_nsx;
      ucode_we <= 1'b0;   // Ends any load burst
      #(PERIOD - 10);
      check_value("upc", upc, e_upc);
      check_value("ctrl", ctrl, e_ctrl);
      check_value("nskip", nskip, e_nskip);
      check_value("flags", flags, e_flags);
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      string       line;
      string       rec;
      string       recs [$];
      int          fd;
      int          code;
      int          cycles;
      arst_n     = 1'b0;
      run        = 1'b0;
      ir         = '0;
      alu_v      = 1'b0;
      alu_l      = 1'b0;
      alu_z      = 1'b0;
      alu_n      = 1'b0;
      cext       = '0;
      nskipext   = 1'b1;
      ucode_we   = 1'b0;
      ucode_addr = '0;
      ucode_data = '0;
      void'($urandom(2576));
      fd = $fopen("tests/control_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file tests/control_stimulus.txt");
         $display("TEST FAILED");
         $fatal(1, "No stimulus");
      end
      cycles = 0;
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code > 0 && (line[0] == "L" || line[0] == "C")) begin
            recs.push_back(line);
            cycles += (line[0] == "L") ? 4 : 1;   // A load record spans 4 cycles
         end
      end
      $fclose(fd);
      limit_ns = longint'(cycles + 3 + 10) * PERIOD;
      repeat (3) @(posedge clk4);
      arst_n <= 1'b1;
      foreach (recs[i]) begin
         rec = recs[i];
         if (rec[0] == "L") begin
            load_block(rec);
         end else begin
            run_cycle(rec);
         end
      end
      repeat (2) @(posedge clk4);   // Let the last assertions complete
      if (dut.u_seq.u_asserts.n_fail != 0) begin
         $display("Sequencer assertions failed %0d times", dut.u_seq.u_asserts.n_fail);
         $display("TEST FAILED");
         $fatal(1, "Assertion failures");
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

   // Stop at the first sequencer assertion failure
   initial begin
      wait (dut.u_seq.u_asserts.n_fail != 0);
      $display("A sequencer assertion failed, see the error above");
      $display("TEST FAILED");
      $fatal(1, "Assertion failure");
   end

   // Watchdog
   initial begin
      wait (limit_ns > 0);
      #(limit_ns);
      $display("Timeout after %0d ns, the stimulus did not finish", limit_ns);
      $display("TEST FAILED");
      $fatal(1, "Watchdog expired");
   end

endmodule

// ==== tests/control_stimulus.txt ====
# L addr w0 w1 w2 w3 : load four microwords from addr (hex, end|fwe|cond|ctrl)
# C run ir alu rnd cext nskipext : exp upc ctrl nskip flags (alu and flags bit0=V..bit3=N)
L 00 00001 10002 0D004 0C008
L 04 30010 01020 00040 27080
L 08 0F100 0F200 0F400 0F800
L 0C 00001 0F003 0F005 00006
L 10 20007 08009 0000A 0A00B
L 14 0900C 3000D 1E00E 0B00F
L 18 0E010 20020 00000 00000
C 0 0000 0 1 0 1 00 000 1 0
C 0 0000 0 1 0 1 00 000 1 0
C 1 1000 0 1 0 1 00 001 1 0
C 1 1000 5 0 0 1 01 002 1 0
C 1 1000 0 1 0 1 02 004 1 5
C 1 1000 0 1 0 1 03 008 1 5
C 1 1000 F 0 0 1 04 000 0 5
C 1 1000 0 1 0 1 05 020 1 5
C 1 1000 0 1 0 1 06 000 0 5
C 1 2040 0 1 0 1 07 080 1 5
C 1 2004 0 1 0 1 08 100 1 5
C 1 2014 0 1 0 1 09 200 1 5
C 1 2014 0 1 0 1 0A 000 0 5
C 1 200A 0 1 0 1 0B 800 1 5
C 1 200A 0 1 0 1 0C 000 0 5
C 1 201A 0 1 0 1 0D 003 1 5
C 1 2001 0 1 0 1 0E 005 1 5
C 1 2001 0 1 0 0 0F 006 1 5
C 1 3000 0 1 0 1 10 000 0 5
C 1 3000 0 1 6 1 11 009 1 5
C 1 3000 0 1 0 1 12 000 0 5
C 1 3000 0 1 4 1 13 00B 1 5
C 1 3000 0 1 5 1 14 00C 1 5
C 1 3000 A 0 0 1 15 000 0 5
C 1 3000 8 0 0 1 16 00E 1 5
C 1 3000 0 1 0 1 17 000 0 8
C 1 3000 0 1 0 1 18 010 1 8
C 0 3000 0 1 0 1 19 000 1 8
C 1 3000 0 1 0 1 19 020 1 8
C 1 3000 0 1 0 1 0C 001 1 8
C 1 3000 0 1 0 1 0D 003 1 8
C 1 3000 0 1 0 1 0E 000 0 8
C 0 3000 0 1 0 1 0F 000 1 8

// ==== all.f ====
source/uc_pkg.sv
source/ucode_store.sv
source/flag_reg.sv
source/skip_unit.sv
source/micro_seq.sv
source/control_top.sv
tests/control_asserts.sv
tests/control_tb.sv

// ==== Bender.yml ====
package:
  name: ucode_control

sources:
  - files:
      - source/uc_pkg.sv
      - source/ucode_store.sv
      - source/flag_reg.sv
      - source/skip_unit.sv
      - source/micro_seq.sv
      - source/control_top.sv
  - target: test
    files:
      - tests/control_asserts.sv
      - tests/control_tb.sv
